//--- Makefile
# verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= data_cache_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/burst_ram_model.sv
/*
  behavioral burst ram for the cache testbench
  answers read bursts two cycles after the command and stores write bursts
*/
`include "cache_settings.svh"
`timescale 1ns/1ps

module burst_ram_model (
  input  logic                     clk,
  input  logic                     rst,
  input  burst_ram_pkg::ram_cmd_e  br_cmd,
  input  logic                     br_cmd_en,
  input  burst_ram_pkg::ram_addr_t br_addr,
  input  burst_ram_pkg::ram_beat_t br_wr_data,
  output burst_ram_pkg::ram_beat_t br_rd_data,
  output logic                     br_rd_data_valid
);

  import burst_ram_pkg::*;

  localparam int DEPTH = 2 ** `CACHE_RAM_DEPTH_W;
  localparam int BEATS = `CACHE_RAM_BEATS;
  localparam int WORDS_PER_BEAT = `CACHE_RAM_BEAT_W / 32;
  localparam int RD_LAT = 2;

  ram_beat_t mem [DEPTH];

  // write burst in progress
  ram_addr_t wr_addr;
  int        wr_left;
  // read burst in progress
  ram_addr_t rd_addr;
  int        rd_wait;
  int        rd_left;

  always_ff @(posedge clk) begin
    if (rst) begin
      // every word starts at its own byte address xor a marker
      for (int i = 0; i < DEPTH; i++) begin
        for (int s = 0; s < WORDS_PER_BEAT; s++) begin
          mem[i][s*32 +: 32] <= 32'((i * WORDS_PER_BEAT + s) * 4) ^ 32'hc0de0000;
        end
      end
      wr_left <= 0;
      rd_left <= 0;
      rd_wait <= 0;
      br_rd_data <= '0;
      br_rd_data_valid <= 1'b0;
    end else begin
      br_rd_data_valid <= 1'b0;
      // beat 0 comes with the command, the rest on the next cycles
      if (br_cmd_en && br_cmd == RAM_WRITE) begin
        mem[br_addr] <= br_wr_data;
        wr_addr <= br_addr + 1'b1;
        wr_left <= BEATS - 1;
      end else if (wr_left > 0) begin
        mem[wr_addr] <= br_wr_data;
        wr_addr <= wr_addr + 1'b1;
        wr_left <= wr_left - 1;
      end
      if (br_cmd_en && br_cmd == RAM_READ) begin
        rd_addr <= br_addr;
        rd_wait <= RD_LAT - 1;
        rd_left <= BEATS;
      end else if (rd_left > 0) begin
        if (rd_wait > 0) begin
          rd_wait <= rd_wait - 1;
        end else begin
          // four beats back to back
          br_rd_data <= mem[rd_addr];
          br_rd_data_valid <= 1'b1;
          rd_addr <= rd_addr + 1'b1;
          rd_left <= rd_left - 1;
        end
      end
    end
  end

endmodule

//--- bench/data_cache_cases.txt
// op (1 read, 2 write, 3 read with enable held), byte address, byte mask,
// write data, expected read word (0 for writes)
1 00000014 0 00000000 c0de0014
1 00000008 0 00000000 c0de0008
2 00000014 5 11223344 00000000
1 00000014 0 00000000 c0220044
1 00000044 0 00000000 c0de0044
1 00000014 0 00000000 c0220044
2 00000038 f deadbeef 00000000
1 00000038 0 00000000 deadbeef
2 00000124 8 a5000000 00000000
1 00000124 0 00000000 a5de0124
3 00000038 0 00000000 deadbeef
1 00000124 0 00000000 a5de0124
1 00000010 0 00000000 c0de0010

//--- bench/data_cache_sva.sv
/*
  assertions on the cache strobes and busy
  bound into the data cache top, see the bind at the end
*/
`timescale 1ns/1ps

module data_cache_sva (
  input logic                  clk,
  input logic                  rst,
  input logic                  accept,
  input cache_pkg::byte_mask_t byte_en,
  input logic                  busy,
  input logic                  data_out_valid,
  input logic                  br_cmd_en
);

  import cache_pkg::*;

  int   failures = 0;
  // last accepted request was a write
  logic write_open;

  always_ff @(posedge clk) begin
    if (rst) begin
      write_open <= 1'b0;
    end else if (accept) begin
      write_open <= (byte_en != '0);
    end
  end

  // ram command strobe is a single-cycle pulse
  cmd_pulse: assert property (@(posedge clk) disable iff (rst) br_cmd_en |=> !br_cmd_en)
    else begin
      $error("br_cmd_en high on two cycles in a row");
      failures++;
    end

  // writes never return data
  no_write_data: assert property (@(posedge clk) disable iff (rst)
      write_open |-> !data_out_valid)
    else begin
      $error("data_out_valid raised during a write request");
      failures++;
    end

  // quiet outputs once reset has been seen
  quiet_after_reset: assert property (@(posedge clk)
      rst |=> !busy && !data_out_valid && !br_cmd_en)
    else begin
      $error("busy or a strobe high right after reset");
      failures++;
    end

endmodule

bind data_cache data_cache_sva i_sva (
  .clk            (clk),
  .rst            (rst),
  .accept         (accept),
  .byte_en        (byte_en),
  .busy           (busy),
  .data_out_valid (data_out_valid),
  .br_cmd_en      (br_cmd_en)
);

//--- bench/data_cache_tb.sv
/*
  testbench for the data cache, one request per line of the cases file
  a burst ram model sits on the ram side, a small reference model predicts misses
*/
`include "cache_settings.svh"
`timescale 1ns/1ps

module data_cache_tb;

  import cache_pkg::*;
  import burst_ram_pkg::*;

  localparam int MAX_CASES = 64;
  localparam int TIMEOUT = 200;
  localparam int LINES = 2 ** `CACHE_LINE_IX_W;
  localparam int LINE_LSB = `CACHE_BYTE_OFS_W + `CACHE_WORD_IX_W;
  localparam int WORDS_PER_BEAT = `CACHE_RAM_BEAT_W / `CACHE_WORD_W;
  localparam int MEM_WORDS = (2 ** `CACHE_RAM_DEPTH_W) * WORDS_PER_BEAT;
  localparam word_t PATTERN = 32'hc0de0000;
  // op codes of the cases file, 1 is a plain read
  localparam logic [31:0] OP_WRITE = 2;
  localparam logic [31:0] OP_READ_HOLD = 3;

  logic      clk;
  logic      rst;
  logic      enable;
  addr_t     address;
  byte_mask_t byte_en;
  word_t     data_in;
  word_t     data_out;
  logic      data_out_valid;
  logic      busy;
  ram_cmd_e  br_cmd;
  logic      br_cmd_en;
  ram_addr_t br_addr;
  ram_beat_t br_wr_data;
  ram_beat_t br_rd_data;
  logic      br_rd_data_valid;

  // five words per case: op, address, mask, write data, expected word
  logic [31:0] case_words [5 * MAX_CASES];
  // what a read of each ram word should return at this point
  word_t arch_mem [MEM_WORDS];
  // expected tag state of the cache
  tag_t ref_tag   [LINES];
  logic ref_valid [LINES];
  logic ref_dirty [LINES];
  int   errors;
  int   checks;
  int   n;
  logic timed_out;

  always #10 clk = ~clk;

  data_cache i_dut (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .address          (address),
    .byte_en          (byte_en),
    .data_in          (data_in),
    .data_out         (data_out),
    .data_out_valid   (data_out_valid),
    .busy             (busy),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  burst_ram_model i_ram (
    .clk              (clk),
    .rst              (rst),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_ram_cmd(input string name, input ram_cmd_e exp, input ram_cmd_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_ram_addr(input string name, input ram_addr_t exp, input ram_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // ram beat address of a line start, byte address / 8
  function automatic ram_addr_t line_beat_addr(input addr_t byte_addr);
    addr_t base;
    base = byte_addr;
    base[LINE_LSB-1:0] = '0;
    return ram_addr_t'(base >> $clog2(`CACHE_RAM_BEAT_W / 8));
  endfunction

  function automatic int word_index(input addr_t byte_addr);
    return int'((byte_addr >> `CACHE_BYTE_OFS_W) % MEM_WORDS);
  endfunction

  // one request from acceptance until busy is low again
  task automatic run_request(input int ix, input logic [31:0] op, input addr_t addr,
                             input byte_mask_t mask, input word_t wdata, input word_t exp);
    string     name;
    line_ix_t  line;
    tag_t      tag;
    logic      hit;
    logic      wb;
    logic      is_read;
    logic      done;
    logic      saw_busy;
    addr_t     victim;
    ram_beat_t beat;
    ram_cmd_e  cmd_q[$];
    ram_addr_t addr_q[$];
    ram_cmd_e  exp_cmd[$];
    ram_addr_t exp_addr[$];
    int        cyc;
    int        valid_cnt;
    word_t     got;
    name = $sformatf("case %0d at %h", ix, addr);
    line = line_ix_t'(addr >> LINE_LSB);
    tag = tag_t'(addr >> (LINE_LSB + `CACHE_LINE_IX_W));
    hit = ref_valid[line] && (ref_tag[line] == tag);
    wb = !hit && ref_valid[line] && ref_dirty[line];
    is_read = (op != OP_WRITE);
    victim = {ref_tag[line], line, {LINE_LSB{1'b0}}};
    enable = 1'b1;
    address = addr;
    byte_en = mask;
    data_in = wdata;
    @(posedge clk);
    #2;
    // held enable must not start a second request
    if (op != OP_READ_HOLD) begin
      enable = 1'b0;
    end
    cyc = 0;
    done = 1'b0;
    saw_busy = 1'b0;
    valid_cnt = 0;
    got = '0;
    while (!done && !timed_out) begin
      if (br_cmd_en) begin
        cmd_q.push_back(br_cmd);
        addr_q.push_back(br_addr);
      end
      if (data_out_valid) begin
        valid_cnt++;
        got = data_out;
      end
      if (!busy) begin
        done = 1'b1;
      end else if (cyc == TIMEOUT) begin
        timed_out = 1'b1;
        errors++;
        $display("timeout: busy still high %0d cycles into %s", TIMEOUT, name);
      end else begin
        saw_busy = 1'b1;
        @(posedge clk);
        #2;
        cyc++;
      end
    end
    enable = 1'b0;
    if (timed_out) begin
      return;
    end
    // dirty victim goes out first, then the line is fetched
    if (wb) begin
      exp_cmd.push_back(RAM_WRITE);
      exp_addr.push_back(line_beat_addr(victim));
    end
    if (!hit) begin
      exp_cmd.push_back(RAM_READ);
      exp_addr.push_back(line_beat_addr(addr));
    end
    check_count({name, " ram commands"}, exp_cmd.size(), cmd_q.size());
    for (int i = 0; i < exp_cmd.size() && i < cmd_q.size(); i++) begin
      check_ram_cmd({name, " ram command"}, exp_cmd[i], cmd_q[i]);
      check_ram_addr({name, " ram address"}, exp_addr[i], addr_q[i]);
    end
    check_flag({name, " busy"}, !hit, saw_busy);
    check_count({name, " read strobes"}, is_read ? 1 : 0, valid_cnt);
    if (is_read) begin
      check_word({name, " read word"}, exp, got);
    end
    // ram now holds the evicted line as last written
    if (wb) begin
      for (int b = 0; b < `CACHE_RAM_BEATS; b++) begin
        beat = i_ram.mem[line_beat_addr(victim) + ram_addr_t'(b)];
        for (int s = 0; s < WORDS_PER_BEAT; s++) begin
          check_word({name, " write-back"},
                     arch_mem[word_index(victim) + b * WORDS_PER_BEAT + s],
                     beat[s*`CACHE_WORD_W +: `CACHE_WORD_W]);
        end
      end
    end
    if (!hit) begin
      ref_valid[line] = 1'b1;
      ref_tag[line] = tag;
      ref_dirty[line] = 1'b0;
    end
    if (!is_read) begin
      ref_dirty[line] = 1'b1;
      for (int b = 0; b < `CACHE_WORD_W / 8; b++) begin
        if (mask[b]) begin
          arch_mem[word_index(addr)][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    enable = 1'b0;
    address = '0;
    byte_en = '0;
    data_in = '0;
    errors = 0;
    checks = 0;
    timed_out = 1'b0;
    for (int i = 0; i < 5 * MAX_CASES; i++) begin
      case_words[i] = '1;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      arch_mem[i] = word_t'(i * 4) ^ PATTERN;
    end
    for (int l = 0; l < LINES; l++) begin
      ref_tag[l] = '0;
      ref_valid[l] = 1'b0;
      ref_dirty[l] = 1'b0;
    end
    $readmemh("bench/data_cache_cases.txt", case_words);
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    check_flag("after reset busy", 1'b0, busy);
    check_flag("after reset data_out_valid", 1'b0, data_out_valid);
    check_flag("after reset br_cmd_en", 1'b0, br_cmd_en);
    // all ones in the op word marks the end of the cases
    n = 0;
    while (n < MAX_CASES && case_words[5*n] !== '1 && !timed_out) begin
      run_request(n, case_words[5*n], case_words[5*n+1], byte_mask_t'(case_words[5*n+2]),
                  case_words[5*n+3], case_words[5*n+4]);
      n++;
    end
    if (n == 0) begin
      errors++;
      $display("no request was read from the cases file");
    end
    errors = errors + i_dut.i_sva.failures;
    $display("%0d cases, %0d checks, %0d errors", n, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+design
design/cache_pkg.sv
design/burst_ram_pkg.sv
design/cache_ctrl_fsm.sv
design/burst_beat_counter.sv
design/cache_line_store.sv
design/data_cache.sv
bench/burst_ram_model.sv
bench/data_cache_sva.sv
bench/data_cache_tb.sv

//--- design/burst_beat_counter.sv
/*
  beat index within one ram burst, shared by controller and line store
*/
`include "cache_settings.svh"
`timescale 1ns/1ps

module burst_beat_counter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear,
  input  logic                    advance,
  output burst_ram_pkg::beat_ix_t beat_ix,
  output logic                    last_beat
);

  import burst_ram_pkg::*;

  localparam beat_ix_t LAST_IX = beat_ix_t'(`CACHE_RAM_BEATS - 1);

  // final beat of the burst, same flag for both users
  assign last_beat = (beat_ix == LAST_IX);

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_ix <= '0;
    end else if (clear) begin
      // clear wins over advance
      beat_ix <= '0;
    end else if (advance) begin
      // wrap after the last beat
      beat_ix <= last_beat ? '0 : beat_ix + 1'b1;
    end
  end

endmodule

//--- design/burst_ram_pkg.sv
/*
  types of the burst ram side: beat address, beat data, beat index, command
*/
package burst_ram_pkg;

  `include "cache_settings.svh"

  // byte address / 8, always taken at a line start
  typedef logic [`CACHE_RAM_DEPTH_W-1:0] ram_addr_t;

  // two words per beat, even word index in the low half
  typedef logic [`CACHE_RAM_BEAT_W-1:0] ram_beat_t;

  typedef logic [$clog2(`CACHE_RAM_BEATS)-1:0] beat_ix_t;

  typedef enum logic {
    RAM_READ,
    RAM_WRITE
  } ram_cmd_e;

endpackage

//--- design/cache_ctrl_fsm.sv
/*
  cache controller: accepts one request at a time and runs the
  write-back and fetch bursts of a miss, driving busy and the ram strobes
*/
`timescale 1ns/1ps

module cache_ctrl_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,
  input  logic                    hit,
  input  logic                    victim_dirty,
  input  logic                    br_rd_data_valid,
  input  logic                    last_beat,
  output logic                    busy,
  output logic                    br_cmd_en,
  output burst_ram_pkg::ram_cmd_e br_cmd,
  output logic                    accept,
  output logic                    start_write_back,
  output logic                    start_fetch,
  output logic                    fill_beat,
  output logic                    finish_fetch,
  output logic                    beat_clear,
  output logic                    beat_advance
);

  import cache_pkg::*;
  import burst_ram_pkg::*;

  cache_state_e state;
  cache_state_e state_next;

  // a request only gets in while idle, enable is ignored otherwise
  assign accept = enable && (state == IDLE);

  // dirty victim goes out first
  assign start_write_back = accept && !hit && victim_dirty;

  // fetch starts straight from idle on a clean miss,
  // or right after the last write-back beat
  assign start_fetch = (accept && !hit && !victim_dirty) ||
                       ((state == WRITE_BACK) && last_beat);

  // ram marks each returned beat, four in a row
  assign fill_beat = br_rd_data_valid &&
                     ((state == FETCH_WAIT) || (state == FETCH_RECV));
  assign finish_fetch = fill_beat && last_beat;

  // counter restarts for every burst
  assign beat_clear = accept || start_fetch;
  // write-back beats go out one per cycle, fetch beats follow the ram
  assign beat_advance = (state == WRITE_BACK) || fill_beat;

  // anything but idle means a miss is in progress
  assign busy = (state != IDLE);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (start_write_back) begin
          state_next = WRITE_BACK;
        end else if (start_fetch) begin
          state_next = FETCH_WAIT;
        end
      end
      WRITE_BACK: begin
        // beat 3 is on the bus now, read command goes out next
        if (last_beat) begin
          state_next = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        // variable delay until the first beat
        if (fill_beat) begin
          state_next = FETCH_RECV;
        end
      end
      FETCH_RECV: begin
        if (finish_fetch) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      br_cmd_en <= 1'b0;
      br_cmd <= RAM_READ;
    end else begin
      state <= state_next;
      // command strobe lasts exactly one cycle
      br_cmd_en <= start_write_back || start_fetch;
      if (start_write_back) begin
        br_cmd <= RAM_WRITE;
      end else if (start_fetch) begin
        br_cmd <= RAM_READ;
      end
    end
  end

endmodule

//--- design/cache_line_store.sv
/*
  cache storage: tags, valid and dirty bits, line data and the latched request
  answers hits, merges written bytes, fills fetched beats, supplies write-back beats
*/
`include "cache_settings.svh"
`timescale 1ns/1ps

module cache_line_store (
  input  logic                     clk,
  input  logic                     rst,
  input  cache_pkg::addr_t         address,
  input  cache_pkg::byte_mask_t    byte_en,
  input  cache_pkg::word_t         data_in,
  input  logic                     accept,
  input  logic                     start_write_back,
  input  logic                     start_fetch,
  input  logic                     fill_beat,
  input  logic                     finish_fetch,
  input  burst_ram_pkg::beat_ix_t  beat_ix,
  input  burst_ram_pkg::ram_beat_t br_rd_data,
  output logic                     hit,
  output logic                     victim_dirty,
  output cache_pkg::word_t         data_out,
  output logic                     data_out_valid,
  output burst_ram_pkg::ram_addr_t br_addr,
  output burst_ram_pkg::ram_beat_t br_wr_data
);

  import cache_pkg::*;
  import burst_ram_pkg::*;

  localparam int LINES = 2 ** `CACHE_LINE_IX_W;
  localparam int WORDS = 2 ** `CACHE_WORD_IX_W;
  localparam int W = `CACHE_WORD_W;
  localparam int WORDS_PER_BEAT = `CACHE_RAM_BEAT_W / W;
  localparam int LINE_LSB = `CACHE_BYTE_OFS_W + `CACHE_WORD_IX_W;
  localparam int TAG_LSB = LINE_LSB + `CACHE_LINE_IX_W;
  // byte address to ram beat address
  localparam int RAM_SHIFT = `CACHE_BYTE_OFS_W + $clog2(WORDS_PER_BEAT);

  tag_t             tags  [LINES];
  word_t            lines [LINES][WORDS];
  logic [LINES-1:0] valid;
  logic [LINES-1:0] dirty;

  // request held for the whole miss
  addr_t      req_addr;
  byte_mask_t req_mask;
  word_t      req_data;

  // fields of the live request on accept, of the latched one afterwards
  addr_t      cur_addr;
  tag_t       cur_tag;
  line_ix_t   cur_line;
  word_ix_t   cur_word;
  word_t      wr_data;
  byte_mask_t wr_mask;
  logic       wr_hit;
  logic       do_write;
  logic       rd_hit;
  logic       rd_fill;

  function automatic word_t merge_bytes(word_t old_word, word_t new_word, byte_mask_t mask);
    word_t res;
    res = old_word;
    for (int b = 0; b < W / 8; b++) begin
      if (mask[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // line start as a ram beat address
  function automatic ram_addr_t ram_line_addr(tag_t line_tag, line_ix_t line);
    addr_t byte_addr;
    byte_addr = {line_tag, line, {LINE_LSB{1'b0}}};
    return byte_addr[RAM_SHIFT +: `CACHE_RAM_DEPTH_W];
  endfunction

  assign cur_addr = accept ? address : req_addr;
  assign cur_tag  = cur_addr[TAG_LSB +: $bits(tag_t)];
  assign cur_line = cur_addr[LINE_LSB +: `CACHE_LINE_IX_W];
  assign cur_word = cur_addr[`CACHE_BYTE_OFS_W +: `CACHE_WORD_IX_W];
  assign wr_data  = accept ? data_in : req_data;
  assign wr_mask  = accept ? byte_en : req_mask;

  assign hit = valid[cur_line] && (tags[cur_line] == cur_tag);
  assign victim_dirty = valid[cur_line] && dirty[cur_line];

  // write hit merges at once, write miss merges over the fetched line
  assign wr_hit   = accept && hit && (byte_en != '0);
  assign do_write = wr_hit || (finish_fetch && (req_mask != '0));

  // read word comes from the array on a hit, from the ram beat on a miss
  assign rd_hit  = accept && hit && (byte_en == '0);
  assign rd_fill = fill_beat && (req_mask == '0) &&
                   (beat_ix_t'(cur_word / WORDS_PER_BEAT) == beat_ix);

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr <= address;
      req_mask <= byte_en;
      req_data <= data_in;
    end
  end

  // per word: fill from the beat first, then lay the request bytes on top
  always_ff @(posedge clk) begin
    word_t nxt;
    for (int l = 0; l < LINES; l++) begin
      for (int w = 0; w < WORDS; w++) begin
        nxt = lines[l][w];
        if (fill_beat && line_ix_t'(l) == cur_line &&
            beat_ix_t'(w / WORDS_PER_BEAT) == beat_ix) begin
          nxt = br_rd_data[(w % WORDS_PER_BEAT) * W +: W];
        end
        if (do_write && line_ix_t'(l) == cur_line && word_ix_t'(w) == cur_word) begin
          nxt = merge_bytes(nxt, wr_data, wr_mask);
        end
        lines[l][w] <= nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
    end else if (finish_fetch) begin
      // line becomes valid only once all beats are in
      valid[cur_line] <= 1'b1;
      dirty[cur_line] <= (req_mask != '0);
    end else if (wr_hit) begin
      dirty[cur_line] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (finish_fetch) begin
      tags[cur_line] <= cur_tag;
    end
  end

  // single-cycle read strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_valid <= 1'b0;
    end else begin
      data_out_valid <= rd_hit || rd_fill;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hit) begin
      data_out <= lines[cur_line][cur_word];
    end else if (rd_fill) begin
      data_out <= br_rd_data[int'(cur_word % WORDS_PER_BEAT) * W +: W];
    end
  end

  // victim address from its stored tag, fetch address from the request
  always_ff @(posedge clk) begin
    if (start_write_back) begin
      br_addr <= ram_line_addr(tags[cur_line], cur_line);
    end else if (start_fetch) begin
      br_addr <= ram_line_addr(cur_tag, cur_line);
    end
  end

  // write-back beat follows the counter, beat 0 is ready with the command
  always_comb begin
    for (int s = 0; s < WORDS_PER_BEAT; s++) begin
      br_wr_data[s*W +: W] = lines[cur_line][int'(beat_ix) * WORDS_PER_BEAT + s];
    end
  end

endmodule

//--- design/cache_pkg.sv
/*
  types of the cache side: address fields, data word and controller states
*/
package cache_pkg;

  `include "cache_settings.svh"

  // full byte address as seen by the request source
  typedef logic [`CACHE_ADDR_W-1:0] addr_t;

  typedef logic [`CACHE_WORD_W-1:0] word_t;

  // one enable per byte of a word, all zero means read
  typedef logic [`CACHE_WORD_W/8-1:0] byte_mask_t;

  // upper address bits kept per line
  typedef logic [`CACHE_ADDR_W-`CACHE_LINE_IX_W-`CACHE_WORD_IX_W-`CACHE_BYTE_OFS_W-1:0] tag_t;

  typedef logic [`CACHE_LINE_IX_W-1:0] line_ix_t;
  typedef logic [`CACHE_WORD_IX_W-1:0] word_ix_t;

  // controller states
  // write back only runs when the victim line is dirty
  typedef enum logic [1:0] {
    IDLE,
    WRITE_BACK,
    FETCH_WAIT,
    FETCH_RECV
  } cache_state_e;

endpackage

//--- design/cache_settings.svh
/*
  geometry of the data cache and the burst RAM behind it
  include wherever the numbers are needed
*/
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// byte address and cached word
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32

// |tag|line|word|00| split of a byte address
`define CACHE_BYTE_OFS_W 2
`define CACHE_WORD_IX_W 3
`define CACHE_LINE_IX_W 1

// ram side moves 64-bit beats, one line per burst
// beats * beat width must equal words per line * word width
`define CACHE_RAM_BEAT_W 64
`define CACHE_RAM_BEATS 4

// ram beat address width, 2 KB in total
`define CACHE_RAM_DEPTH_W 8

`endif

//--- design/data_cache.sv
/*
  direct-mapped write-back data cache in front of a burst ram
  top level, joins controller, beat counter and line store
*/
`timescale 1ns/1ps

module data_cache (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     enable,
  input  cache_pkg::addr_t         address,
  input  cache_pkg::byte_mask_t    byte_en,
  input  cache_pkg::word_t         data_in,
  output cache_pkg::word_t         data_out,
  output logic                     data_out_valid,
  output logic                     busy,
  output burst_ram_pkg::ram_cmd_e  br_cmd,
  output logic                     br_cmd_en,
  output burst_ram_pkg::ram_addr_t br_addr,
  output burst_ram_pkg::ram_beat_t br_wr_data,
  input  burst_ram_pkg::ram_beat_t br_rd_data,
  input  logic                     br_rd_data_valid
);

  import burst_ram_pkg::*;

  // controller strobes to the store
  logic accept;
  logic start_write_back;
  logic start_fetch;
  logic fill_beat;
  logic finish_fetch;
  // lookup results back to the controller
  logic hit;
  logic victim_dirty;
  // beat counter
  logic     beat_clear;
  logic     beat_advance;
  beat_ix_t beat_ix;
  logic     last_beat;

  cache_ctrl_fsm i_fsm (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .hit              (hit),
    .victim_dirty     (victim_dirty),
    .br_rd_data_valid (br_rd_data_valid),
    .last_beat        (last_beat),
    .busy             (busy),
    .br_cmd_en        (br_cmd_en),
    .br_cmd           (br_cmd),
    .accept           (accept),
    .start_write_back (start_write_back),
    .start_fetch      (start_fetch),
    .fill_beat        (fill_beat),
    .finish_fetch     (finish_fetch),
    .beat_clear       (beat_clear),
    .beat_advance     (beat_advance)
  );

  burst_beat_counter i_beats (
    .clk       (clk),
    .rst       (rst),
    .clear     (beat_clear),
    .advance   (beat_advance),
    .beat_ix   (beat_ix),
    .last_beat (last_beat)
  );

  cache_line_store i_store (
    .clk              (clk),
    .rst              (rst),
    .address          (address),
    .byte_en          (byte_en),
    .data_in          (data_in),
    .accept           (accept),
    .start_write_back (start_write_back),
    .start_fetch      (start_fetch),
    .fill_beat        (fill_beat),
    .finish_fetch     (finish_fetch),
    .beat_ix          (beat_ix),
    .br_rd_data       (br_rd_data),
    .hit              (hit),
    .victim_dirty     (victim_dirty),
    .data_out         (data_out),
    .data_out_valid   (data_out_valid),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data)
  );

endmodule
